//--- hw/phy_cmd_macros.svh
// widths and bit positions of the command word, replayed control bits and PHY lanes
`ifndef PHY_CMD_MACROS_SVH
`define PHY_CMD_MACROS_SVH

// command word
`define PHY_CMD_W       32  // one command word per mclk
`define PHY_ADDR_W      15  // row/column address, also pause length on NOP
`define PHY_BANK_W      3   // bank address
`define PHY_RCW_W       3   // {ras,cas,we}

// NOP fields packed in the address
`define PHY_PAUSE_BITS  10  // low address bits give the pause length
`define PHY_DONE_BIT    10  // address bit flagging the end of a sequence

// replayed control bits, odt down to buf_rst
`define PHY_EXTRA_W     10

// tristate sequencing
`define PHY_TRI_W       8   // one bit per quarter of the serializer word
`define PHY_PAT_W       4   // transition pattern, sent twice

// lane encodings
`define PHY_RCW_NOP     3'b111  // active-low {ras,cas,we} for NOP
`define PHY_DQS_W       8   // dqs toggle pattern width

`endif

//--- hw/phy_cmd_pkg.sv
// packed struct types for command word, effective command, patterns, buffer strobes and lanes
`include "phy_cmd_macros.svh"

package phy_cmd_pkg;

    // raw command word as it arrives from the sequencer, msb first
    typedef struct packed {
        logic [`PHY_ADDR_W-1:0] addr;      // address, or pause length/done on NOP
        logic [`PHY_BANK_W-1:0] bank;      // bank address
        logic [`PHY_RCW_W-1:0]  rcw;       // positive logic {ras,cas,we}, 0 is NOP
        logic                   odt;       // on-die termination
        logic                   cke_dis;   // 1 drops cke, xor-ed with ddr_cke
        logic                   sel;       // 1 puts command in the second half-cycle
        logic                   dq_en;     // drive dq lines
        logic                   dqs_en;    // drive dqs lines
        logic                   dqs_toggle; // toggle dqs from pattern
        logic                   dci_en;    // enable dci on dq/dqs
        logic                   buf_wr;    // external buffer write
        logic                   buf_rd;    // external buffer read
        logic                   add_pause_req; // ask for one inserted pause
        logic                   buf_rst;   // buffer address back to page start
    } cmd_word_t;

    // control bits kept across a pause, same order as in the word
    typedef struct packed {
        logic odt;
        logic cke_dis;
        logic sel;
        logic dq_en;
        logic dqs_en;
        logic dqs_toggle;
        logic dci_en;
        logic buf_wr;
        logic buf_rd;
        logic buf_rst;
    } cmd_extra_t;

    // command in effect for this mclk cycle
    typedef struct packed {
        logic [`PHY_RCW_W-1:0]  rcw;    // positive logic, 0 on pause
        cmd_extra_t             extra;  // replayed on pause
        logic [`PHY_ADDR_W-1:0] addr;   // calm address
        logic [`PHY_BANK_W-1:0] bank;   // calm bank
    } cmd_cur_t;

    // quasi-static configuration levels
    typedef struct packed {
        logic [`PHY_DQS_W-1:0] dqs_pattern; // typically 8'h55
        logic [`PHY_PAT_W-1:0] dq_tri_on;   // first dq tri word when turning on
        logic [`PHY_PAT_W-1:0] dq_tri_off;  // first dq tri word when turning off
        logic [`PHY_PAT_W-1:0] dqs_tri_on;
        logic [`PHY_PAT_W-1:0] dqs_tri_off;
    } phy_pattern_t;

    typedef struct packed {
        logic wr;
        logic rd;
        logic rst;
    } buf_ctl_t;

    // per-half-cycle lanes, [1] is the second half
    typedef struct packed {
        logic [2*`PHY_ADDR_W-1:0] addr;
        logic [2*`PHY_BANK_W-1:0] bank;
        logic [1:0]               ras;      // active low
        logic [1:0]               cas;      // active low
        logic [1:0]               we;       // active low
        logic [1:0]               cke;
        logic [1:0]               odt;
        logic [`PHY_TRI_W-1:0]    dq_tri;   // 1 = tristated
        logic [`PHY_TRI_W-1:0]    dqs_tri;
        logic [`PHY_DQS_W-1:0]    dqs_data;
        logic                     dci_dis_dq;
        logic                     dci_dis_dqs;
    } phy_lanes_t;

endpackage

//--- hw/phy_tri_seq.sv
// tristate control sequencer, steady level or on/off transition pattern
`timescale 1ns/100ps
`include "phy_cmd_macros.svh"

module phy_tri_seq (
    input  logic                  mclk,
    input  logic                  mrst,     // sync, active high
    input  logic                  en,       // drive the lines this cycle
    input  logic [`PHY_PAT_W-1:0] on_pat,   // first word after tristated -> driven
    input  logic [`PHY_PAT_W-1:0] off_pat,  // first word after driven -> tristated
    output logic [`PHY_TRI_W-1:0] tri_word  // 1 = tristate, one bit per quarter
);

    localparam int REP = `PHY_TRI_W / `PHY_PAT_W;  // pattern repeats per word

    logic tri_lvl;   // requested tristate level
    logic tri_prev;  // level of the previous cycle

    assign tri_lvl = ~en;

    always_comb begin
        if (tri_prev == tri_lvl)
            tri_word = {`PHY_TRI_W{tri_lvl}};  // no transition
        else if (tri_prev)
            tri_word = {REP{on_pat}};          // turning output on
        else
            tri_word = {REP{off_pat}};         // turning output off
    end

    // lines come out of reset tristated
    always_ff @(posedge mclk) begin
        if (mrst)
            tri_prev <= 1'b1;
        else
            tri_prev <= tri_lvl;
    end

endmodule

//--- hw/phy_lane_pack.sv
// lane packer with half-cycle command placement, cke/odt duplication, dci and dqs data
`timescale 1ns/100ps
`include "phy_cmd_macros.svh"

module phy_lane_pack
    import phy_cmd_pkg::*;
(
    input  cmd_cur_t              cmd_cur,      // effective command
    input  logic                  ddr_cke,      // cke level, xor-ed with cke_dis
    input  logic [`PHY_DQS_W-1:0] dqs_pattern,  // toggle pattern for dqs
    input  logic [`PHY_TRI_W-1:0] dq_tri,       // from dq sequencer
    input  logic [`PHY_TRI_W-1:0] dqs_tri,      // from dqs sequencer
    output phy_lanes_t            lanes
);

    logic [`PHY_RCW_W-1:0] rcw_n;   // active-low {ras,cas,we}
    logic [`PHY_RCW_W-1:0] rcw_hi;  // second half-cycle
    logic [`PHY_RCW_W-1:0] rcw_lo;  // first half-cycle
    logic                  cke_lvl;
    logic                  dci_dis;

    assign rcw_n   = ~cmd_cur.rcw;
    // command goes in one half and the other half is a NOP
    assign rcw_hi  = cmd_cur.extra.sel ? rcw_n : `PHY_RCW_NOP;
    assign rcw_lo  = cmd_cur.extra.sel ? `PHY_RCW_NOP : rcw_n;
    assign cke_lvl = cmd_cur.extra.cke_dis ^ ddr_cke;
    assign dci_dis = ~cmd_cur.extra.dci_en;

    always_comb begin
        lanes.addr = {cmd_cur.addr, cmd_cur.addr};  // same address both halves
        lanes.bank = {cmd_cur.bank, cmd_cur.bank};

        lanes.ras  = {rcw_hi[2], rcw_lo[2]};
        lanes.cas  = {rcw_hi[1], rcw_lo[1]};
        lanes.we   = {rcw_hi[0], rcw_lo[0]};

        lanes.cke  = {2{cke_lvl}};
        lanes.odt  = {2{cmd_cur.extra.odt}};

        lanes.dq_tri  = dq_tri;
        lanes.dqs_tri = dqs_tri;

        // dqs held low when not toggling keeps the write-leveling preamble clean
        lanes.dqs_data = cmd_cur.extra.dqs_toggle ? dqs_pattern : '0;

        lanes.dci_dis_dq  = dci_dis;
        // odt set during write leveling turns dqs dci off while dq dci stays on
        lanes.dci_dis_dqs = dci_dis | cmd_cur.extra.odt;
    end

endmodule

//--- hw/phy_cmd_decode.sv
// command word decoder with hold register for calm address and pause replay
`timescale 1ns/100ps
`include "phy_cmd_macros.svh"

module phy_cmd_decode
    import phy_cmd_pkg::*;
(
    input  logic                       mclk,
    input  logic                       mrst,          // sync, active high
    input  cmd_word_t                  cmd_word,      // new word every cycle
    input  logic                       add_pause,     // repeat previous settings as NOP
    output cmd_cur_t                   cmd_cur,       // effective command
    output logic                       cmd_nop,       // real NOP, inserted pause excluded
    output logic                       cmd_add_pause, // word asks for a pause
    output logic                       sequence_done,
    output logic [`PHY_PAUSE_BITS-1:0] pause_len,
    output buf_ctl_t                   buf_ctl
);

    cmd_extra_t             word_extra;  // control bits of the incoming word
    logic                   calm;        // keep address/bank from last real command
    logic                   done_flag;   // done bit of a NOP word

    // state from the last word that was not a NOP
    logic [`PHY_ADDR_W-1:0] hold_addr;
    logic [`PHY_BANK_W-1:0] hold_bank;
    cmd_extra_t             hold_extra;

    always_comb begin
        word_extra.odt        = cmd_word.odt;
        word_extra.cke_dis    = cmd_word.cke_dis;
        word_extra.sel        = cmd_word.sel;
        word_extra.dq_en      = cmd_word.dq_en;
        word_extra.dqs_en     = cmd_word.dqs_en;
        word_extra.dqs_toggle = cmd_word.dqs_toggle;
        word_extra.dci_en     = cmd_word.dci_en;
        word_extra.buf_wr     = cmd_word.buf_wr;
        word_extra.buf_rd     = cmd_word.buf_rd;
        word_extra.buf_rst    = cmd_word.buf_rst;
    end

    assign cmd_nop       = (cmd_word.rcw == '0) && !add_pause; // inserted pause is not a NOP here
    assign cmd_add_pause = cmd_word.add_pause_req;
    assign calm          = cmd_nop || add_pause;
    assign done_flag     = cmd_word.addr[`PHY_DONE_BIT];

    assign sequence_done = cmd_nop && done_flag;
    // done bit wins over any leftover length bits
    assign pause_len     = done_flag ? '0 : cmd_word.addr[`PHY_PAUSE_BITS-1:0];

    always_comb begin
        if (add_pause) begin
            cmd_cur.rcw   = '0;          // NOP in place of the command
            cmd_cur.extra = hold_extra;  // previous odt, enables, strobes
        end else begin
            cmd_cur.rcw   = cmd_word.rcw;
            cmd_cur.extra = word_extra;
        end
        cmd_cur.addr = calm ? hold_addr : cmd_word.addr; // no address toggling on NOPs
        cmd_cur.bank = calm ? hold_bank : cmd_word.bank;
    end

    always_comb begin
        buf_ctl.wr  = cmd_cur.extra.buf_wr;
        buf_ctl.rd  = cmd_cur.extra.buf_rd;
        buf_ctl.rst = cmd_cur.extra.buf_rst;
    end

    // pause cycles load too, the word still carries the same bits
    always_ff @(posedge mclk) begin
        if (mrst) begin
            hold_addr  <= '0;
            hold_bank  <= '0;
            hold_extra <= '0;
        end else if (!cmd_nop) begin
            hold_addr  <= cmd_word.addr;
            hold_bank  <= cmd_word.bank;
            hold_extra <= word_extra;
        end
    end

endmodule

//--- hw/phy_cmd_top.sv
// top of the PHY command front end, decoder, two tristate sequencers and lane packer
`timescale 1ns/100ps
`include "phy_cmd_macros.svh"

module phy_cmd_top
    import phy_cmd_pkg::*;
(
    input  logic                       mclk,          // half ddr clock
    input  logic                       mrst,          // sync, active high
    input  cmd_word_t                  cmd_word,      // from the command sequencer
    input  logic                       add_pause,     // repeat previous settings as NOP
    input  logic                       ddr_cke,       // global cke level
    input  phy_pattern_t               patterns,      // quasi-static config
    output logic                       cmd_nop,
    output logic                       cmd_add_pause,
    output logic [`PHY_PAUSE_BITS-1:0] pause_len,
    output logic                       sequence_done,
    output buf_ctl_t                   buf_ctl,       // external buffer strobes
    output phy_lanes_t                 lanes          // to the PHY serializers
);

    cmd_cur_t              cmd_cur;      // effective command, decode -> packer
    logic [`PHY_TRI_W-1:0] dq_tri_word;
    logic [`PHY_TRI_W-1:0] dqs_tri_word;

    phy_cmd_decode decode_i (
        .mclk          (mclk),
        .mrst          (mrst),
        .cmd_word      (cmd_word),
        .add_pause     (add_pause),
        .cmd_cur       (cmd_cur),
        .cmd_nop       (cmd_nop),
        .cmd_add_pause (cmd_add_pause),
        .sequence_done (sequence_done),
        .pause_len     (pause_len),
        .buf_ctl       (buf_ctl)
    );

    // dq lines
    phy_tri_seq dq_seq_i (
        .mclk     (mclk),
        .mrst     (mrst),
        .en       (cmd_cur.extra.dq_en),
        .on_pat   (patterns.dq_tri_on),
        .off_pat  (patterns.dq_tri_off),
        .tri_word (dq_tri_word)
    );

    // dqs lines, own patterns for preamble/postamble timing
    phy_tri_seq dqs_seq_i (
        .mclk     (mclk),
        .mrst     (mrst),
        .en       (cmd_cur.extra.dqs_en),
        .on_pat   (patterns.dqs_tri_on),
        .off_pat  (patterns.dqs_tri_off),
        .tri_word (dqs_tri_word)
    );

    phy_lane_pack pack_i (
        .cmd_cur     (cmd_cur),
        .ddr_cke     (ddr_cke),
        .dqs_pattern (patterns.dqs_pattern),
        .dq_tri      (dq_tri_word),
        .dqs_tri     (dqs_tri_word),
        .lanes       (lanes)
    );

endmodule

//--- testbench/phy_cmd_model.svh
// reference model of the command front end with state copies, field helpers and prediction
`ifndef PHY_CMD_MODEL_SVH
`define PHY_CMD_MODEL_SVH

// model copies of the hold register and previous tristate levels
logic [`PHY_ADDR_W-1:0]     m_hold_addr;
logic [`PHY_BANK_W-1:0]     m_hold_bank;
cmd_extra_t                 m_hold_extra;
logic                       m_dq_prev;      // 1 = lines were tristated
logic                       m_dqs_prev;

// predicted outputs for the current cycle
logic                       exp_nop;
logic                       exp_add_pause;
logic [`PHY_PAUSE_BITS-1:0] exp_pause_len;
logic                       exp_done;
buf_ctl_t                   exp_buf;
phy_lanes_t                 exp_lanes;

// the ten replayable control bits of a word by name
function automatic cmd_extra_t extra_of(input cmd_word_t w);
    cmd_extra_t ex;
    ex.odt        = w.odt;
    ex.cke_dis    = w.cke_dis;
    ex.sel        = w.sel;
    ex.dq_en      = w.dq_en;
    ex.dqs_en     = w.dqs_en;
    ex.dqs_toggle = w.dqs_toggle;
    ex.dci_en     = w.dci_en;
    ex.buf_wr     = w.buf_wr;
    ex.buf_rd     = w.buf_rd;
    ex.buf_rst    = w.buf_rst;
    return ex;
endfunction

// tri word from the previous and the requested tristate level
function automatic logic [`PHY_TRI_W-1:0] expected_tri(input logic prev, input logic lvl,
                                                       input logic [`PHY_PAT_W-1:0] on_p,
                                                       input logic [`PHY_PAT_W-1:0] off_p);
    if (prev && !lvl)
        return {on_p, on_p};      // tristated -> driven
    if (!prev && lvl)
        return {off_p, off_p};    // driven -> tristated
    return {`PHY_TRI_W{lvl}};     // steady
endfunction

task reset_model;
    begin
        m_hold_addr  = '0;
        m_hold_bank  = '0;
        m_hold_extra = '0;
        m_dq_prev    = 1'b1;  // both lane sets start tristated
        m_dqs_prev   = 1'b1;
    end
endtask

// predicts this cycle's outputs and advances the state copies to the next edge
task predict_cycle(input cmd_word_t w, input logic pause, input logic cke_in,
                   input phy_pattern_t pat);
    cmd_extra_t             ex;
    logic [2:0]             rcw_low;   // active-low command
    logic                   nop;
    logic [`PHY_ADDR_W-1:0] a;
    logic [`PHY_BANK_W-1:0] b;
    logic [1:0]             ras;
    logic [1:0]             cas;
    logic [1:0]             we;
    logic                   dq_lvl;
    logic                   dqs_lvl;
    logic                   done_bit;
    begin
        nop      = (w.rcw == 3'b000) && !pause;
        ex       = pause ? m_hold_extra : extra_of(w);            // pause replays held bits
        rcw_low  = pause ? 3'b111 : ~w.rcw;                       // pause is a NOP on the bus
        a        = (nop || pause) ? m_hold_addr : w.addr;         // calm address
        b        = (nop || pause) ? m_hold_bank : w.bank;
        done_bit = w.addr[`PHY_DONE_BIT];

        exp_nop       = nop;
        exp_add_pause = w.add_pause_req;
        exp_done      = nop && done_bit;
        exp_pause_len = done_bit ? '0 : w.addr[`PHY_PAUSE_BITS-1:0];
        exp_buf.wr    = ex.buf_wr;
        exp_buf.rd    = ex.buf_rd;
        exp_buf.rst   = ex.buf_rst;

        if (ex.sel) begin
            ras = {rcw_low[2], 1'b1};  // upper half carries the command
            cas = {rcw_low[1], 1'b1};
            we  = {rcw_low[0], 1'b1};
        end else begin
            ras = {1'b1, rcw_low[2]};
            cas = {1'b1, rcw_low[1]};
            we  = {1'b1, rcw_low[0]};
        end

        dq_lvl  = !ex.dq_en;
        dqs_lvl = !ex.dqs_en;

        exp_lanes.addr        = {a, a};
        exp_lanes.bank        = {b, b};
        exp_lanes.ras         = ras;
        exp_lanes.cas         = cas;
        exp_lanes.we          = we;
        exp_lanes.cke         = {2{ex.cke_dis ^ cke_in}};
        exp_lanes.odt         = {2{ex.odt}};
        exp_lanes.dq_tri      = expected_tri(m_dq_prev, dq_lvl, pat.dq_tri_on, pat.dq_tri_off);
        exp_lanes.dqs_tri     = expected_tri(m_dqs_prev, dqs_lvl, pat.dqs_tri_on, pat.dqs_tri_off);
        exp_lanes.dqs_data    = ex.dqs_toggle ? pat.dqs_pattern : 8'h00;
        exp_lanes.dci_dis_dq  = !ex.dci_en;
        exp_lanes.dci_dis_dqs = !ex.dci_en || ex.odt;  // odt turns dqs dci off

        if (!nop) begin  // pause words load as well
            m_hold_addr  = w.addr;
            m_hold_bank  = w.bank;
            m_hold_extra = extra_of(w);
        end
        m_dq_prev  = dq_lvl;
        m_dqs_prev = dqs_lvl;
    end
endtask

`endif

//--- testbench/phy_cmd_tb.sv
// testbench for phy_cmd_top with clock, reset, directed tests, seeded random run and checks
`timescale 1ns/100ps
`include "phy_cmd_macros.svh"

module phy_cmd_tb
    import phy_cmd_pkg::*;
;

    logic                       mclk = 1'b0;
    logic                       mrst;
    cmd_word_t                  cmd_word;
    logic                       add_pause;
    logic                       ddr_cke;
    phy_pattern_t               patterns;
    logic                       cmd_nop;
    logic                       cmd_add_pause;
    logic [`PHY_PAUSE_BITS-1:0] pause_len;
    logic                       sequence_done;
    buf_ctl_t                   buf_ctl;
    phy_lanes_t                 lanes;

    int     cycle_cnt  = 0;   // rising edges seen
    int     pass_count = 0;
    int     fail_count = 0;
    int     test_fail  = 0;   // mismatches in the running test
    string  test_name  = "none";
    integer seed       = 32'hfd63;

    `include "phy_cmd_model.svh"

    phy_cmd_top dut_i (
        .mclk          (mclk),
        .mrst          (mrst),
        .cmd_word      (cmd_word),
        .add_pause     (add_pause),
        .ddr_cke       (ddr_cke),
        .patterns      (patterns),
        .cmd_nop       (cmd_nop),
        .cmd_add_pause (cmd_add_pause),
        .pause_len     (pause_len),
        .sequence_done (sequence_done),
        .buf_ctl       (buf_ctl),
        .lanes         (lanes)
    );

    always #4 mclk = ~mclk;  // 8 ns period

    always @(posedge mclk) begin
        cycle_cnt <= cycle_cnt + 1;
    end

    task check_equal(input string field, input logic [79:0] expected, input logic [79:0] actual);
        begin
            if (actual !== expected) begin
                $display("FAILED %s %s: expected %0h actual %0h", test_name, field, expected, actual);
                fail_count = fail_count + 1;
                test_fail  = test_fail + 1;
            end else begin
                pass_count = pass_count + 1;
            end
        end
    endtask

    // polls between clock edges and returns 1 ns after the next rising edge
    task automatic next_edge;
        int target;
        int guard;
        begin
            target = cycle_cnt + 1;
            guard  = 0;
            #0.5;
            while (cycle_cnt < target && guard < 20) begin
                #1;
                guard = guard + 1;
            end
            if (cycle_cnt < target) begin
                $display("timeout: no rising mclk edge seen within 20 ns");
                $display("Simulation FAILED");
                $finish;
            end else begin
                #0.5;
            end
        end
    endtask

    function automatic cmd_word_t build_word(input logic [`PHY_ADDR_W-1:0] a,
                                             input logic [`PHY_BANK_W-1:0] b,
                                             input logic [2:0] rcw, input cmd_extra_t ex,
                                             input logic pause_req);
        cmd_word_t w;
        w               = '0;
        w.addr          = a;
        w.bank          = b;
        w.rcw           = rcw;
        w.odt           = ex.odt;
        w.cke_dis       = ex.cke_dis;
        w.sel           = ex.sel;
        w.dq_en         = ex.dq_en;
        w.dqs_en        = ex.dqs_en;
        w.dqs_toggle    = ex.dqs_toggle;
        w.dci_en        = ex.dci_en;
        w.buf_wr        = ex.buf_wr;
        w.buf_rd        = ex.buf_rd;
        w.buf_rst       = ex.buf_rst;
        w.add_pause_req = pause_req;
        return w;
    endfunction

    task compare_outputs;
        begin
            check_equal("cmd_nop", exp_nop, cmd_nop);
            check_equal("cmd_add_pause", exp_add_pause, cmd_add_pause);
            check_equal("pause_len", exp_pause_len, pause_len);
            check_equal("sequence_done", exp_done, sequence_done);
            check_equal("buf_ctl", exp_buf, buf_ctl);
            check_equal("addr", exp_lanes.addr, lanes.addr);
            check_equal("bank", exp_lanes.bank, lanes.bank);
            check_equal("ras", exp_lanes.ras, lanes.ras);
            check_equal("cas", exp_lanes.cas, lanes.cas);
            check_equal("we", exp_lanes.we, lanes.we);
            check_equal("cke", exp_lanes.cke, lanes.cke);
            check_equal("odt", exp_lanes.odt, lanes.odt);
            check_equal("dq_tri", exp_lanes.dq_tri, lanes.dq_tri);
            check_equal("dqs_tri", exp_lanes.dqs_tri, lanes.dqs_tri);
            check_equal("dqs_data", exp_lanes.dqs_data, lanes.dqs_data);
            check_equal("dci_dis_dq", exp_lanes.dci_dis_dq, lanes.dci_dis_dq);
            check_equal("dci_dis_dqs", exp_lanes.dci_dis_dqs, lanes.dci_dis_dqs);
        end
    endtask

    // inputs were driven at edge+1 and are sampled at edge+3
    task settle_and_compare;
        begin
            #2;
            predict_cycle(cmd_word, add_pause, ddr_cke, patterns);
            compare_outputs();
        end
    endtask

    task start_test(input string name);
        begin
            test_name = name;
            test_fail = 0;
        end
    endtask

    task end_test;
        begin
            if (test_fail == 0)
                $display("test %s: ok", test_name);
            else
                $display("test %s: %0d mismatches", test_name, test_fail);
        end
    endtask

    initial begin
        cmd_extra_t  ex;
        int          i;
        logic [31:0] rnd;  // raw random draw

        mrst                 = 1'b1;
        cmd_word             = '0;
        add_pause            = 1'b0;
        ddr_cke              = 1'b1;
        patterns.dqs_pattern = 8'h55;
        patterns.dq_tri_on   = 4'h3;
        patterns.dq_tri_off  = 4'hc;
        patterns.dqs_tri_on  = 4'h1;
        patterns.dqs_tri_off = 4'he;
        reset_model();

        for (i = 0; i < 4; i = i + 1)
            next_edge();  // reset held over 4 rising edges
        mrst = 1'b0;

        // pause right after reset replays the cleared hold register
        start_test("reset_pause");
        cmd_word  = $random(seed);
        add_pause = 1'b1;
        settle_and_compare();
        check_equal("strobes", 3'b000, buf_ctl);
        check_equal("odt_off", 2'b00, lanes.odt);
        check_equal("addr_zero", 30'h0, lanes.addr);
        check_equal("dq_tri_ff", 8'hff, lanes.dq_tri);
        check_equal("dqs_tri_ff", 8'hff, lanes.dqs_tri);
        check_equal("rcw_nop", 6'b111111, {lanes.ras, lanes.cas, lanes.we});
        check_equal("not_nop", 1'b0, cmd_nop);
        next_edge();
        add_pause = 1'b0;
        end_test();

        // real commands in the upper and lower half
        start_test("real_cmd");
        ex       = '0;
        ex.sel   = 1'b1;
        cmd_word = build_word(15'h1234, 3'd5, 3'b011, ex, 1'b0);  // cas+we in upper half
        settle_and_compare();
        check_equal("ras_hi", 2'b11, lanes.ras);
        check_equal("cas_hi", 2'b01, lanes.cas);
        check_equal("we_hi", 2'b01, lanes.we);
        check_equal("addr_twice", {15'h1234, 15'h1234}, lanes.addr);
        check_equal("bank_twice", 6'b101101, lanes.bank);
        check_equal("nop_low", 1'b0, cmd_nop);
        next_edge();
        ex       = '0;
        cmd_word = build_word(15'h2a5a, 3'd3, 3'b100, ex, 1'b0);  // ras in lower half
        settle_and_compare();
        check_equal("ras_lo", 2'b10, lanes.ras);
        check_equal("cas_lo", 2'b11, lanes.cas);
        check_equal("we_lo", 2'b11, lanes.we);
        check_equal("addr_twice2", {15'h2a5a, 15'h2a5a}, lanes.addr);
        check_equal("bank_twice2", 6'b011011, lanes.bank);
        next_edge();
        end_test();

        // NOPs keep the last address and the done bit clears pause_len
        start_test("nop_calm");
        cmd_word = build_word(15'h0123, 3'd6, 3'b000, ex, 1'b0);
        settle_and_compare();
        check_equal("calm_addr", {15'h2a5a, 15'h2a5a}, lanes.addr);
        check_equal("calm_bank", 6'b011011, lanes.bank);
        check_equal("nop_high", 1'b1, cmd_nop);
        check_equal("not_done", 1'b0, sequence_done);
        check_equal("pause_len", 10'h123, pause_len);
        next_edge();
        cmd_word = build_word(15'h04ff, 3'd1, 3'b000, ex, 1'b0);  // bit 10 marks done
        settle_and_compare();
        check_equal("calm_addr2", {15'h2a5a, 15'h2a5a}, lanes.addr);
        check_equal("done", 1'b1, sequence_done);
        check_equal("len_zero", 10'h000, pause_len);
        next_edge();
        end_test();

        // pause replays odt, strobes and enables of the last real command
        start_test("pause_replay");
        ex        = '0;
        ex.odt    = 1'b1;
        ex.buf_wr = 1'b1;
        ex.dq_en  = 1'b1;
        ex.dqs_en = 1'b1;
        ex.dci_en = 1'b1;
        cmd_word  = build_word(15'h0777, 3'd2, 3'b110, ex, 1'b0);
        settle_and_compare();
        check_equal("dq_on_pat", 8'h33, lanes.dq_tri);
        next_edge();
        ex        = '0;
        cmd_word  = build_word(15'h5555, 3'd7, 3'b111, ex, 1'b1);
        add_pause = 1'b1;
        settle_and_compare();
        check_equal("odt_replay", 2'b11, lanes.odt);
        check_equal("buf_wr_replay", 1'b1, buf_ctl.wr);
        check_equal("rcw_nop", 6'b111111, {lanes.ras, lanes.cas, lanes.we});
        check_equal("nop_low", 1'b0, cmd_nop);
        check_equal("pause_req", 1'b1, cmd_add_pause);
        check_equal("held_addr", {15'h0777, 15'h0777}, lanes.addr);
        check_equal("dq_driven", 8'h00, lanes.dq_tri);
        check_equal("dqs_driven", 8'h00, lanes.dqs_tri);
        check_equal("dqs_dci_off", 1'b1, lanes.dci_dis_dqs);
        next_edge();
        add_pause = 1'b0;
        end_test();

        // enable transitions give one pattern cycle and then a steady word
        start_test("tri_seq");
        ex       = '0;
        cmd_word = build_word(15'h0010, 3'd0, 3'b000, ex, 1'b0);
        settle_and_compare();
        check_equal("dq_off_pat", 8'hcc, lanes.dq_tri);
        check_equal("dqs_off_pat", 8'hee, lanes.dqs_tri);
        next_edge();
        settle_and_compare();
        check_equal("dq_steady_off", 8'hff, lanes.dq_tri);
        check_equal("dqs_steady_off", 8'hff, lanes.dqs_tri);
        next_edge();
        ex.dq_en  = 1'b1;
        ex.dqs_en = 1'b1;
        cmd_word  = build_word(15'h0010, 3'd0, 3'b000, ex, 1'b0);
        settle_and_compare();
        check_equal("dq_on_pat", 8'h33, lanes.dq_tri);
        check_equal("dqs_on_pat", 8'h11, lanes.dqs_tri);
        next_edge();
        settle_and_compare();
        check_equal("dq_steady_on", 8'h00, lanes.dq_tri);
        check_equal("dqs_steady_on", 8'h00, lanes.dqs_tri);
        next_edge();
        ex.dqs_en = 1'b0;
        cmd_word  = build_word(15'h0010, 3'd0, 3'b000, ex, 1'b0);
        settle_and_compare();
        check_equal("dq_still_on", 8'h00, lanes.dq_tri);
        check_equal("dqs_off_again", 8'hee, lanes.dqs_tri);
        next_edge();
        end_test();

        // seeded random words against the model every cycle
        start_test("random");
        for (i = 0; i < 400; i = i + 1) begin
            if (i % 64 == 0) begin
                rnd      = $random(seed);
                patterns = rnd[23:0];      // new quasi-static config now and then
            end
            cmd_word = $random(seed);
            if (($random(seed) & 3) == 0)
                cmd_word.rcw = 3'b000;     // about a quarter NOPs
            add_pause = (($random(seed) & 7) == 0);
            rnd       = $random(seed);
            ddr_cke   = rnd[0];
            settle_and_compare();
            next_edge();
        end
        end_test();

        $display("checks: %0d passed, %0d failed", pass_count, fail_count);
        if (fail_count == 0) begin
            $display("Simulation PASSED");
        end else begin
            $display("Simulation FAILED");
        end
        $finish;
    end

endmodule

//--- phy_cmd.f
+incdir+hw
+incdir+testbench
hw/phy_cmd_pkg.sv
hw/phy_tri_seq.sv
hw/phy_lane_pack.sv
hw/phy_cmd_decode.sv
hw/phy_cmd_top.sv
testbench/phy_cmd_tb.sv
